// File: rtl/int_mem_pkg.sv
`default_nettype none

package int_mem_pkg;

   // cpu byte address and bus data widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // one bus request, wstrb all zero means read
   typedef struct packed {
      logic                valid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
   } iob_req_t;

   // one bus response
   // rvalid comes one cycle after an accepted read
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_rsp_t;

   // control register bit positions
   localparam int BOOT_FLAG_BIT = 0;
   localparam int CPU_RST_BIT   = 1;

endpackage

`default_nettype wire

// File: rtl/dp_sram.sv
`timescale 1ns/1ps
`default_nettype none

module dp_sram #(
   parameter int SRAM_ADDR_W = 12
) (
   input  wire logic                  clk_i,
   input  wire int_mem_pkg::iob_req_t a_req_i,
   output      int_mem_pkg::iob_rsp_t a_rsp_o,
   input  wire int_mem_pkg::iob_req_t b_req_i,
   output      int_mem_pkg::iob_rsp_t b_rsp_o
);

   localparam int DATA_W = int_mem_pkg::DATA_W;
   localparam int NB     = DATA_W / 8;
   localparam int DEPTH  = 2 ** (SRAM_ADDR_W - 2);

   logic [DATA_W-1:0]      mem [0:DEPTH-1];
   logic [SRAM_ADDR_W-3:0] a_idx;
   logic [SRAM_ADDR_W-3:0] b_idx;
   logic [DATA_W-1:0]      a_rdata_q;
   logic [DATA_W-1:0]      b_rdata_q;
   logic                   a_rvalid_q;
   logic                   b_rvalid_q;

   assign a_idx = a_req_i.addr[SRAM_ADDR_W-1:2];
   assign b_idx = b_req_i.addr[SRAM_ADDR_W-1:2];

   // port b writes last and wins on a same-word collision
   always_ff @(posedge clk_i) begin
      if (a_req_i.valid) begin
         for (int i = 0; i < NB; i++) begin
            if (a_req_i.wstrb[i]) begin
               mem[a_idx][i*8 +: 8] <= a_req_i.wdata[i*8 +: 8];
            end
         end
         a_rdata_q <= mem[a_idx];
      end
      if (b_req_i.valid) begin
         for (int i = 0; i < NB; i++) begin
            if (b_req_i.wstrb[i]) begin
               mem[b_idx][i*8 +: 8] <= b_req_i.wdata[i*8 +: 8];
            end
         end
         b_rdata_q <= mem[b_idx];
      end
      a_rvalid_q <= a_req_i.valid & ~|a_req_i.wstrb;
      b_rvalid_q <= b_req_i.valid & ~|b_req_i.wstrb;
   end

   // never stalls
   always_comb begin
      a_rsp_o.rdata  = a_rdata_q;
      a_rsp_o.rvalid = a_rvalid_q;
      a_rsp_o.ready  = 1'b1;
      b_rsp_o.rdata  = b_rdata_q;
      b_rsp_o.rvalid = b_rvalid_q;
      b_rsp_o.ready  = 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/ibus_merge.sv
`timescale 1ns/1ps
`default_nettype none

module ibus_merge (
   input  wire int_mem_pkg::iob_req_t boot_req_i,
   input  wire int_mem_pkg::iob_req_t cpu_req_i,
   output      int_mem_pkg::iob_rsp_t cpu_rsp_o,
   output      int_mem_pkg::iob_req_t sram_req_o,
   input  wire int_mem_pkg::iob_rsp_t sram_rsp_i
);

   // fixed priority, boot writes go first
   always_comb begin
      if (boot_req_i.valid) begin
         sram_req_o = boot_req_i;
      end else begin
         sram_req_o = cpu_req_i;
      end
   end

   // boot side only writes, so every read response is the cpu's
   always_comb begin
      cpu_rsp_o.rdata  = sram_rsp_i.rdata;
      cpu_rsp_o.rvalid = sram_rsp_i.rvalid;
      // stall the cpu while the copy owns the port
      cpu_rsp_o.ready  = sram_rsp_i.ready & ~boot_req_i.valid;
   end

endmodule

`default_nettype wire

// File: rtl/dbus_split.sv
`timescale 1ns/1ps
`default_nettype none

module dbus_split #(
   parameter int B_BIT = 31
) (
   input  wire logic                  clk_i,
   input  wire logic                  rst_n_i,
   input  wire int_mem_pkg::iob_req_t cpu_req_i,
   output      int_mem_pkg::iob_rsp_t cpu_rsp_o,
   output      int_mem_pkg::iob_req_t sram_req_o,
   input  wire int_mem_pkg::iob_rsp_t sram_rsp_i,
   output      int_mem_pkg::iob_req_t ctrl_req_o,
   input  wire int_mem_pkg::iob_rsp_t ctrl_rsp_i
);

   logic sel;
   logic rd_accept;
   logic rd_sel_q;

   // high selects the boot controller
   assign sel = cpu_req_i.addr[B_BIT];

   always_comb begin
      sram_req_o       = cpu_req_i;
      sram_req_o.valid = cpu_req_i.valid & ~sel;
      ctrl_req_o       = cpu_req_i;
      ctrl_req_o.valid = cpu_req_i.valid & sel;
   end

   assign rd_accept = cpu_req_i.valid & cpu_rsp_o.ready & ~|cpu_req_i.wstrb;

   // remember the target of the last accepted read
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_sel_q <= 1'b0;
      end else if (rd_accept) begin
         rd_sel_q <= sel;
      end
   end

   always_comb begin
      cpu_rsp_o.ready = sel ? ctrl_rsp_i.ready : sram_rsp_i.ready;
      if (rd_sel_q) begin
         cpu_rsp_o.rdata  = ctrl_rsp_i.rdata;
         cpu_rsp_o.rvalid = ctrl_rsp_i.rvalid;
      end else begin
         cpu_rsp_o.rdata  = sram_rsp_i.rdata;
         cpu_rsp_o.rvalid = sram_rsp_i.rvalid;
      end
   end

endmodule

`default_nettype wire

// File: rtl/boot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8
) (
   input  wire logic                              clk_i,
   input  wire logic                              rst_n_i,
   input  wire int_mem_pkg::iob_req_t             cpu_req_i,
   output      int_mem_pkg::iob_rsp_t             cpu_rsp_o,
   output      logic                              boot_o,
   output      logic                              cpu_rst_o,
   output      int_mem_pkg::iob_req_t             sram_req_o,
   output      logic                              rom_r_valid_o,
   output      logic [BOOTROM_ADDR_W-3:0]         rom_r_addr_o,
   input  wire logic [int_mem_pkg::DATA_W-1:0]    rom_r_rdata_i
);

   localparam int DATA_W = int_mem_pkg::DATA_W;

   logic                      start_q;
   logic                      rd_busy_q;
   logic [BOOTROM_ADDR_W-3:0] rd_addr_q;
   logic                      wr_valid_q;
   logic [BOOTROM_ADDR_W-3:0] wr_addr_q;
   logic                      boot_q;
   logic                      cpu_rst_q;
   logic                      reg_rvalid_q;
   logic [DATA_W-1:0]         reg_rdata_q;
   logic [DATA_W-1:0]         status;
   logic                      reg_rd;
   logic                      reg_wr;
   logic                      restart;
   logic                      copy_start;
   logic [SRAM_ADDR_W-3:0]    wr_word;

   // register access decode, address is not decoded further
   assign reg_rd     = cpu_req_i.valid & ~|cpu_req_i.wstrb;
   assign reg_wr     = cpu_req_i.valid & cpu_req_i.wstrb[0];
   assign restart    = reg_wr & cpu_req_i.wdata[int_mem_pkg::CPU_RST_BIT];
   assign copy_start = start_q | restart;

   // rom read stage, one word per cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         start_q   <= 1'b1;
         rd_busy_q <= 1'b0;
         rd_addr_q <= '0;
      end else begin
         start_q <= 1'b0;
         if (copy_start) begin
            rd_busy_q <= 1'b1;
            rd_addr_q <= '0;
         end else if (rd_busy_q) begin
            rd_addr_q <= rd_addr_q + 1'b1;
            if (&rd_addr_q) begin
               rd_busy_q <= 1'b0;
            end
         end
      end
   end

   assign rom_r_valid_o = rd_busy_q;
   assign rom_r_addr_o  = rd_addr_q;

   // sram write stage follows the rom read by one cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_valid_q <= 1'b0;
      end else begin
         wr_valid_q <= rd_busy_q;
      end
   end

   always_ff @(posedge clk_i) begin
      wr_addr_q <= rd_addr_q;
   end

   // boot program lands in the top region of the sram
   assign wr_word = {{(SRAM_ADDR_W-BOOTROM_ADDR_W){1'b1}}, wr_addr_q};

   always_comb begin
      sram_req_o                     = '0;
      sram_req_o.valid               = wr_valid_q;
      sram_req_o.addr[SRAM_ADDR_W-1:2] = wr_word;
      sram_req_o.wdata               = rom_r_rdata_i;
      sram_req_o.wstrb               = '1;
   end

   // boot flag and cpu reset
   // a new copy in flight keeps the cpu in reset
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         boot_q    <= 1'b1;
         cpu_rst_q <= 1'b1;
      end else begin
         if (wr_valid_q && (&wr_addr_q) && !rd_busy_q) begin
            cpu_rst_q <= 1'b0;
         end
         if (reg_wr) begin
            boot_q <= cpu_req_i.wdata[int_mem_pkg::BOOT_FLAG_BIT];
         end
         if (restart) begin
            boot_q    <= 1'b1;
            cpu_rst_q <= 1'b1;
         end
      end
   end

   assign boot_o    = boot_q;
   assign cpu_rst_o = cpu_rst_q;

   always_comb begin
      status                              = '0;
      status[int_mem_pkg::BOOT_FLAG_BIT]  = boot_q;
      status[int_mem_pkg::CPU_RST_BIT]    = cpu_rst_q;
   end

   // register read response
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         reg_rvalid_q <= 1'b0;
      end else begin
         reg_rvalid_q <= reg_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_rd) begin
         reg_rdata_q <= status;
      end
   end

   always_comb begin
      cpu_rsp_o.rdata  = reg_rdata_q;
      cpu_rsp_o.rvalid = reg_rvalid_q;
      cpu_rsp_o.ready  = 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/int_mem.sv
`timescale 1ns/1ps
`default_nettype none

module int_mem #(
   parameter int SRAM_ADDR_W    = 12,
   parameter int BOOTROM_ADDR_W = 8,
   parameter int B_BIT          = 31
) (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,
   output      logic                           boot_o,
   output      logic                           cpu_reset_o,
   input  wire int_mem_pkg::iob_req_t          i_req_i,
   output      int_mem_pkg::iob_rsp_t          i_rsp_o,
   input  wire int_mem_pkg::iob_req_t          d_req_i,
   output      int_mem_pkg::iob_rsp_t          d_rsp_o,
   output      logic                           rom_r_valid_o,
   output      logic [BOOTROM_ADDR_W-3:0]      rom_r_addr_o,
   input  wire logic [int_mem_pkg::DATA_W-1:0] rom_r_rdata_i
);

   localparam int ADDR_W = int_mem_pkg::ADDR_W;

   // word offset of the boot region at the top of the sram
   localparam logic [SRAM_ADDR_W-3:0] BOOT_OFF =
      (SRAM_ADDR_W-2)'((2 ** (SRAM_ADDR_W-2)) - (2 ** (BOOTROM_ADDR_W-2)));

   int_mem_pkg::iob_req_t i_map_req;
   int_mem_pkg::iob_req_t d_sram_req;
   int_mem_pkg::iob_req_t d_map_req;
   int_mem_pkg::iob_rsp_t d_sram_rsp;
   int_mem_pkg::iob_req_t ctrl_req;
   int_mem_pkg::iob_rsp_t ctrl_rsp;
   int_mem_pkg::iob_req_t boot_wr_req;
   int_mem_pkg::iob_req_t ram_a_req;
   int_mem_pkg::iob_rsp_t ram_a_rsp;

   // keep sram bits only, shift into the boot region while booting
   function automatic logic [ADDR_W-1:0] map_addr(input logic [ADDR_W-1:0] addr,
                                                  input logic              boot);
      logic [SRAM_ADDR_W-3:0] word;
      word = addr[SRAM_ADDR_W-1:2];
      if (boot) begin
         word = word + BOOT_OFF;
      end
      map_addr                  = '0;
      map_addr[SRAM_ADDR_W-1:2] = word;
   endfunction

   always_comb begin
      i_map_req      = i_req_i;
      i_map_req.addr = map_addr(i_req_i.addr, boot_o);
      d_map_req      = d_sram_req;
      d_map_req.addr = map_addr(d_sram_req.addr, boot_o);
   end

   dbus_split #(
      .B_BIT(B_BIT)
   ) i_dbus_split (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .cpu_req_i (d_req_i),
      .cpu_rsp_o (d_rsp_o),
      .sram_req_o(d_sram_req),
      .sram_rsp_i(d_sram_rsp),
      .ctrl_req_o(ctrl_req),
      .ctrl_rsp_i(ctrl_rsp)
   );

   boot_ctrl #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W)
   ) i_boot_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cpu_req_i    (ctrl_req),
      .cpu_rsp_o    (ctrl_rsp),
      .boot_o       (boot_o),
      .cpu_rst_o    (cpu_reset_o),
      .sram_req_o   (boot_wr_req),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i)
   );

   // boot writes share the instruction port
   ibus_merge i_ibus_merge (
      .boot_req_i(boot_wr_req),
      .cpu_req_i (i_map_req),
      .cpu_rsp_o (i_rsp_o),
      .sram_req_o(ram_a_req),
      .sram_rsp_i(ram_a_rsp)
   );

   dp_sram #(
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) i_dp_sram (
      .clk_i  (clk_i),
      .a_req_i(ram_a_req),
      .a_rsp_o(ram_a_rsp),
      .b_req_i(d_map_req),
      .b_rsp_o(d_sram_rsp)
   );

endmodule

`default_nettype wire

// File: dv/int_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_mem_tb;

   localparam int SRAM_ADDR_W    = 12;
   localparam int BOOTROM_ADDR_W = 8;
   localparam int B_BIT          = 31;
   localparam int SRAM_WORDS     = 2 ** (SRAM_ADDR_W - 2);
   localparam int ROM_WORDS      = 2 ** (BOOTROM_ADDR_W - 2);
   localparam int TIMEOUT        = 500;
   localparam logic [31:0] CTRL_ADDR = 32'h1 << B_BIT;

   logic                      clk_i;
   logic                      rst_n_i;
   logic                      boot_o;
   logic                      cpu_reset_o;
   int_mem_pkg::iob_req_t     i_req;
   int_mem_pkg::iob_rsp_t     i_rsp;
   int_mem_pkg::iob_req_t     d_req;
   int_mem_pkg::iob_rsp_t     d_rsp;
   logic                      rom_r_valid_o;
   logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o;
   logic [31:0]               rom_r_rdata_i = '0;

   logic [31:0]               rom_mem [ROM_WORDS];
   logic [31:0]               ram_model [SRAM_WORDS];
   bit                        known [SRAM_WORDS];
   logic                      rom_hit;
   logic [BOOTROM_ADDR_W-3:0] rom_idx;
   int                        errors;
   int                        checks;
   int                        tests;
   int                        base_errors;
   int                        stall_cnt;

   int_mem #(
      .SRAM_ADDR_W   (SRAM_ADDR_W),
      .BOOTROM_ADDR_W(BOOTROM_ADDR_W),
      .B_BIT         (B_BIT)
   ) i_dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o),
      .i_req_i      (i_req),
      .i_rsp_o      (i_rsp),
      .d_req_i      (d_req),
      .d_rsp_o      (d_rsp),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // external rom model answers one cycle after a read
   always @(negedge clk_i) begin
      rom_hit = rom_r_valid_o;
      rom_idx = rom_r_addr_o;
      @(posedge clk_i);
      #1;
      if (rom_hit) begin
         rom_r_rdata_i = rom_mem[rom_idx];
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == base_errors) ? "ok" : "failed");
      base_errors = errors;
   endtask

   // word index that the sram sees under the boot remapping
   function automatic int map_word(input logic [31:0] addr, input bit boot);
      int w;
      w = int'(addr[SRAM_ADDR_W-1:2]);
      if (boot) begin
         w = (w + SRAM_WORDS - ROM_WORDS) % SRAM_WORDS;
      end
      return w;
   endfunction

   // random upper bits with bit B_BIT kept clear
   function automatic logic [31:0] word_addr(input int w);
      logic [31:0] a;
      a = $urandom;
      a[B_BIT] = 1'b0;
      a[SRAM_ADDR_W-1:0] = {w[SRAM_ADDR_W-3:0], 2'b00};
      return a;
   endfunction

   task automatic copy_rom();
      for (int k = 0; k < ROM_WORDS; k++) begin
         ram_model[SRAM_WORDS - ROM_WORDS + k] = rom_mem[k];
         known[SRAM_WORDS - ROM_WORDS + k] = 1'b1;
      end
   endtask

   task automatic wait_cpu_reset(input logic level);
      int n;
      n = 0;
      while (cpu_reset_o !== level && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (cpu_reset_o !== level) begin
         report_timeout(level ? "cpu_reset_o rise" : "cpu_reset_o fall");
      end
   endtask

   // one transfer on the instruction or data bus
   task automatic bus_access(input bit use_d, input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
      int_mem_pkg::iob_req_t req;
      bit                    hit;
      int                    n;
      req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      rdata = '0;
      stall_cnt = 0;
      hit = 1'b0;
      n = 0;
      @(posedge clk_i);
      #1;
      if (use_d) d_req = req;
      else i_req = req;
      while (!hit && n < TIMEOUT) begin
         @(negedge clk_i);
         hit = use_d ? d_rsp.ready : i_rsp.ready;
         stall_cnt += hit ? 0 : 1;
         n++;
      end
      if (!hit) report_timeout(use_d ? "d_rsp_o.ready" : "i_rsp_o.ready");
      @(posedge clk_i);
      #1;
      if (use_d) d_req = '0;
      else i_req = '0;
      if (hit && wstrb == 4'h0) begin
         hit = 1'b0;
         n = 0;
         while (!hit && n < TIMEOUT) begin
            @(negedge clk_i);
            hit = use_d ? d_rsp.rvalid : i_rsp.rvalid;
            n++;
         end
         if (hit) begin
            rdata = use_d ? d_rsp.rdata : i_rsp.rdata;
            // rvalid belongs in the cycle right after acceptance
            check(use_d ? "d_rsp_o.rvalid delay" : "i_rsp_o.rvalid delay", n, 1);
         end else begin
            report_timeout(use_d ? "d_rsp_o.rvalid" : "i_rsp_o.rvalid");
         end
      end else if (hit) begin
         // a write returns no read response
         @(negedge clk_i);
         check(use_d ? "d_rsp_o.rvalid" : "i_rsp_o.rvalid",
               {31'h0, (use_d ? d_rsp.rvalid : i_rsp.rvalid)}, 32'h0);
      end
   endtask

   task automatic data_write(input logic [31:0] addr, input logic [3:0] strb);
      logic [31:0] wd;
      logic [31:0] unused_rd;
      int          w;
      wd = $urandom;
      w = map_word(addr, boot_o);
      bus_access(1'b1, addr, wd, strb, unused_rd);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) ram_model[w][b*8 +: 8] = wd[b*8 +: 8];
      end
      if (strb == 4'hf) known[w] = 1'b1;
   endtask

   task automatic read_check(input bit use_d, input logic [31:0] addr);
      logic [31:0] rd;
      int          w;
      w = map_word(addr, boot_o);
      bus_access(use_d, addr, 32'h0, 4'h0, rd);
      check(use_d ? "d_rsp_o.rdata" : "i_rsp_o.rdata", rd, ram_model[w]);
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] a;
      int          w;
      int          n;
      errors = 0;
      checks = 0;
      tests = 0;
      base_errors = 0;
      void'($urandom(32'h865b_9435));
      i_req = '0;
      d_req = '0;
      rst_n_i = 1'b0;
      foreach (rom_mem[k]) rom_mem[k] = $urandom;
      foreach (known[k]) known[k] = 1'b0;

      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      check("boot_o", {31'h0, boot_o}, 32'h1);
      check("cpu_reset_o", {31'h0, cpu_reset_o}, 32'h1);
      check("rom_r_valid_o", {31'h0, rom_r_valid_o}, 32'h0);
      check("i_rsp_o.rvalid", {31'h0, i_rsp.rvalid}, 32'h0);
      check("d_rsp_o.rvalid", {31'h0, d_rsp.rvalid}, 32'h0);
      @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      wait_cpu_reset(1'b0);
      check("boot_o", {31'h0, boot_o}, 32'h1);
      copy_rom();
      finish_test("reset and boot copy end");

      for (int k = 0; k < ROM_WORDS; k++) begin
         read_check(1'b0, word_addr(k));
         read_check(1'b1, word_addr(k));
      end
      finish_test("boot program readback");

      // boot region gets partial writes
      repeat (120) begin
         a = word_addr($urandom_range(ROM_WORDS - 1));
         if ($urandom_range(1) == 1) data_write(a, 4'($urandom_range(15, 1)));
         else read_check(1'b1, a);
      end
      finish_test("data traffic in boot mapping");

      bus_access(1'b1, CTRL_ADDR, 32'h0, 4'h0, rd);
      check("d_rsp_o.rdata ctrl", rd, 32'h1);
      bus_access(1'b1, CTRL_ADDR, 32'h0, 4'h1, rd);
      @(negedge clk_i);
      check("boot_o", {31'h0, boot_o}, 32'h0);
      bus_access(1'b1, CTRL_ADDR, 32'h0, 4'h0, rd);
      check("d_rsp_o.rdata ctrl", rd, 32'h0);
      finish_test("control register");

      repeat (150) begin
         w = $urandom_range(SRAM_WORDS - 1);
         a = word_addr(w);
         if (!known[w]) data_write(a, 4'hf);
         read_check(1'($urandom_range(1)), a);
      end
      // instruction reads after a copy restart stall behind the boot writes
      bus_access(1'b1, CTRL_ADDR, 32'h3, 4'h1, rd);
      @(negedge clk_i);
      check("cpu_reset_o", {31'h0, cpu_reset_o}, 32'h1);
      check("boot_o", {31'h0, boot_o}, 32'h1);
      copy_rom();
      n = 0;
      while (i_rsp.ready && n < TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (i_rsp.ready) report_timeout("instruction bus stall");
      for (int k = 0; k < 8; k++) begin
         read_check(1'b0, word_addr($urandom_range(ROM_WORDS - 1)));
         if (k == 0) check("i_rsp_o.ready stalled", (stall_cnt > 0) ? 32'h1 : 32'h0, 32'h1);
      end
      wait_cpu_reset(1'b0);
      check("boot_o", {31'h0, boot_o}, 32'h1);
      finish_test("normal mapping and restart");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
rtl/int_mem_pkg.sv
rtl/dp_sram.sv
rtl/ibus_merge.sv
rtl/dbus_split.sv
rtl/boot_ctrl.sv
rtl/int_mem.sv
dv/int_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the int_mem testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f all.f --top-module int_mem_tb -o int_mem_sim; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/int_mem_sim 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
   exit 0
fi
exit 1
